// ==== common/isa_pkg.sv ====
package isa_pkg;

  typedef logic [3:0]  nibble_t;
  typedef logic [7:0]  imm8_t;
  typedef logic [11:0] opcode_t;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    PUSH_WAIT,
    DONE
  } exec_state_t;

  // Immediate loads, operand in the low nibble
  localparam opcode_t LD_A_BASE  = 12'hE00;
  localparam opcode_t LD_B_BASE  = 12'hE10;

  // Byte loads into XH:XL and YH:YL, operand in the low byte
  localparam opcode_t LD_X_BASE  = 12'hB00;
  localparam opcode_t LD_Y_BASE  = 12'h800;

  // Page loads from a register, r in bits 1:0
  localparam opcode_t LD_XP_BASE = 12'hE80;
  localparam opcode_t LD_YP_BASE = 12'hE90;

  localparam opcode_t SET_F_BASE = 12'hF40;
  localparam opcode_t RST_F_BASE = 12'hF50;

  localparam opcode_t PUSH_BASE  = 12'hFC0;
  localparam opcode_t DEC_SP     = 12'hFCB;
  localparam opcode_t INC_SP     = 12'hFDB;

  // r field codes, MX and MY (2 and 3) have no read path here
  localparam logic [1:0] REG_A = 2'd0;
  localparam logic [1:0] REG_B = 2'd1;

  // PUSH operand codes above the r range
  localparam nibble_t PUSH_XP = 4'h4;
  localparam nibble_t PUSH_XH = 4'h5;
  localparam nibble_t PUSH_XL = 4'h6;
  localparam nibble_t PUSH_YP = 4'h7;
  localparam nibble_t PUSH_YH = 4'h8;
  localparam nibble_t PUSH_YL = 4'h9;
  localparam nibble_t PUSH_F  = 4'hA;

endpackage

// ==== common/stack_pkg.sv ====
package stack_pkg;

  localparam int STACK_ADDR_W = 8;
  localparam int STACK_DATA_W = 4;

  // Stack sits in page 0 of data memory
  typedef logic [STACK_ADDR_W-1:0] stack_addr_t;
  typedef logic [STACK_DATA_W-1:0] stack_data_t;

  // One pending stack write as held in the buffer
  typedef struct packed {
    stack_addr_t addr;
    stack_data_t data;
  } stack_cmd_t;

endpackage

// ==== common/stack_wr_if.sv ====
`timescale 1ns/10ps

interface stack_wr_if
  import stack_pkg::*;
();

  logic        req;
  logic        ack;
  stack_addr_t addr;
  stack_data_t data;

  modport producer (
    output req,
    output addr,
    output data,
    input  ack
  );

  modport consumer (
    input  req,
    input  addr,
    input  data,
    output ack
  );

endinterface

// ==== core/insn_exec.sv ====
`timescale 1ns/10ps

module insn_exec
  import isa_pkg::*, stack_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         op_req,
  input  opcode_t      opcode,
  output logic         op_ack,
  output stack_addr_t  sp,
  stack_wr_if.producer wr
);

  exec_state_t state;
  opcode_t     op_q;
  imm8_t       imm8;
  nibble_t     a;
  nibble_t     b;
  nibble_t     xp;
  nibble_t     xh;
  nibble_t     xl;
  nibble_t     yp;
  nibble_t     yh;
  nibble_t     yl;
  nibble_t     f;
  nibble_t     push_data;
  logic        push_req;

  assign imm8 = op_q[7:0];

  // FC2 and FC3 (MX, MY) fall through as no-ops
  function automatic logic is_push(input opcode_t op);
    logic hit;
    hit = 1'b0;
    if (op[11:4] == PUSH_BASE[11:4]) begin
      case (op[3:0])
        {2'b00, REG_A}, {2'b00, REG_B}: hit = 1'b1;
        PUSH_XP, PUSH_XH, PUSH_XL: hit = 1'b1;
        PUSH_YP, PUSH_YH, PUSH_YL: hit = 1'b1;
        PUSH_F: hit = 1'b1;
        default: hit = 1'b0;
      endcase
    end
    return hit;
  endfunction

  function automatic nibble_t push_src(input nibble_t sel);
    nibble_t src;
    case (sel)
      {2'b00, REG_B}: src = b;
      PUSH_XP: src = xp;
      PUSH_XH: src = xh;
      PUSH_XL: src = xl;
      PUSH_YP: src = yp;
      PUSH_YH: src = yh;
      PUSH_YL: src = yl;
      PUSH_F:  src = f;
      default: src = a;
    endcase
    return src;
  endfunction

  always_ff @(posedge clk) begin
    if (state == IDLE && op_req)
      op_q <= opcode;
    if (state == EXEC)
      push_data <= push_src(op_q[3:0]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      op_ack   <= 1'b0;
      push_req <= 1'b0;
      a        <= '0;
      b        <= '0;
      xp       <= '0;
      xh       <= '0;
      xl       <= '0;
      yp       <= '0;
      yh       <= '0;
      yl       <= '0;
      f        <= '0;
      sp       <= 8'h00;
    end else begin
      case (state)
        IDLE: begin
          if (op_req)
            state <= EXEC;
        end
        EXEC: begin
          if (is_push(op_q)) begin
            // Pre-decrement so the write goes to the new SP
            sp    <= sp - 8'd1;
            state <= PUSH_WAIT;
          end else begin
            if (op_q[11:4] == LD_A_BASE[11:4])
              a <= op_q[3:0];
            else if (op_q[11:4] == LD_B_BASE[11:4])
              b <= op_q[3:0];
            else if (op_q[11:8] == LD_X_BASE[11:8])
              {xh, xl} <= imm8;
            else if (op_q[11:8] == LD_Y_BASE[11:8])
              {yh, yl} <= imm8;
            else if (op_q[11:2] == LD_XP_BASE[11:2]) begin
              if (op_q[1:0] == REG_A)
                xp <= a;
              else if (op_q[1:0] == REG_B)
                xp <= b;
            end else if (op_q[11:2] == LD_YP_BASE[11:2]) begin
              if (op_q[1:0] == REG_A)
                yp <= a;
              else if (op_q[1:0] == REG_B)
                yp <= b;
            end else if (op_q[11:4] == SET_F_BASE[11:4])
              f <= f | op_q[3:0];
            else if (op_q[11:4] == RST_F_BASE[11:4])
              f <= f & op_q[3:0];
            else if (op_q == DEC_SP)
              sp <= sp - 8'd1;
            else if (op_q == INC_SP)
              sp <= sp + 8'd1;
            op_ack <= 1'b1;
            state  <= DONE;
          end
        end
        PUSH_WAIT: begin
          if (!push_req && !wr.ack) begin
            push_req <= 1'b1;
          end else if (push_req && wr.ack) begin
            push_req <= 1'b0;
            op_ack   <= 1'b1;
            state    <= DONE;
          end
        end
        DONE: begin
          if (!op_req) begin
            op_ack <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign wr.req  = push_req;
  assign wr.addr = sp;
  assign wr.data = push_data;

endmodule

// ==== core/stack_fifo.sv ====
`timescale 1ns/10ps

module stack_fifo
  import stack_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst,
  stack_wr_if.consumer in_wr,
  stack_wr_if.producer out_wr,
  output logic         empty
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  stack_cmd_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             in_ack;
  logic             out_req;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
  endfunction

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  // Holding ack low while full is the back-pressure
  assign push  = in_wr.req && !in_ack && !full;
  assign pop   = out_req && out_wr.ack;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= '{addr: in_wr.addr, data: in_wr.data};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      in_ack  <= 1'b0;
      out_req <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
        in_ack <= 1'b1;
      end else if (!in_wr.req) begin
        in_ack <= 1'b0;
      end
      if (pop) begin
        rd_ptr  <= next_ptr(rd_ptr);
        out_req <= 1'b0;
      end else if (!out_req && !out_wr.ack && !empty) begin
        out_req <= 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  assign in_wr.ack   = in_ack;
  assign out_wr.req  = out_req;
  assign out_wr.addr = mem[rd_ptr].addr;
  assign out_wr.data = mem[rd_ptr].data;

endmodule

// ==== src/stack_ram.sv ====
`timescale 1ns/10ps

module stack_ram
  import stack_pkg::*;
#(
  parameter int STACK_WORDS = 256
) (
  input  logic         clk,
  input  logic         rst,
  stack_wr_if.consumer wr,
  input  stack_addr_t  rd_addr,
  output stack_data_t  rd_data,
  output logic         busy
);

  stack_data_t mem [STACK_WORDS];
  logic        ack_q;
  logic        take;

  // New request, not yet acknowledged
  assign take = wr.req && !ack_q;

  always_ff @(posedge clk) begin
    if (take)
      mem[wr.addr] <= wr.data;
  end

  always_ff @(posedge clk) begin
    if (rst)
      ack_q <= 1'b0;
    else if (take)
      ack_q <= 1'b1;
    else if (!wr.req)
      ack_q <= 1'b0;
  end

  assign wr.ack  = ack_q;
  assign busy    = wr.req || ack_q;
  assign rd_data = mem[rd_addr];

endmodule

// ==== src/push_unit_top.sv ====
`timescale 1ns/10ps

module push_unit_top
  import isa_pkg::*, stack_pkg::*;
#(
  parameter int FIFO_DEPTH  = 4,
  parameter int STACK_WORDS = 256
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        op_req,
  input  opcode_t     opcode,
  output logic        op_ack,
  output stack_addr_t sp,
  input  stack_addr_t rd_addr,
  output stack_data_t rd_data,
  output logic        idle
);

  logic fifo_empty;
  logic ram_busy;

  stack_wr_if exec_wr ();
  stack_wr_if ram_wr ();

  insn_exec exec_i (
    .clk    (clk),
    .rst    (rst),
    .op_req (op_req),
    .opcode (opcode),
    .op_ack (op_ack),
    .sp     (sp),
    .wr     (exec_wr)
  );

  stack_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk    (clk),
    .rst    (rst),
    .in_wr  (exec_wr),
    .out_wr (ram_wr),
    .empty  (fifo_empty)
  );

  stack_ram #(
    .STACK_WORDS (STACK_WORDS)
  ) ram_i (
    .clk     (clk),
    .rst     (rst),
    .wr      (ram_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .busy    (ram_busy)
  );

  // Nothing buffered and no RAM write in flight
  assign idle = fifo_empty && !ram_busy;

endmodule

// ==== verif/push_unit_tb.sv ====
`timescale 1ns/10ps

module push_unit_tb
  import isa_pkg::*, stack_pkg::*;
();

  localparam int FIFO_DEPTH  = 4;
  localparam int STACK_WORDS = 256;
  localparam int BURST_LEN   = FIFO_DEPTH + 6;
  // 15 register ops, 8 flag ops, 2 no-ops, 12 SP steps, 12 burst ops
  localparam int N_OPS       = 49;

  logic        clk;
  logic        rst;
  logic        op_req;
  opcode_t     opcode;
  logic        op_ack;
  stack_addr_t sp;
  stack_addr_t rd_addr;
  stack_data_t rd_data;
  logic        idle;

  int    seed = 32'h0c2b1d83;
  string test_name;
  event  op_done;

  // Reference model state
  nibble_t     ref_a;
  nibble_t     ref_b;
  nibble_t     ref_xp;
  nibble_t     ref_xh;
  nibble_t     ref_xl;
  nibble_t     ref_yp;
  nibble_t     ref_yh;
  nibble_t     ref_yl;
  nibble_t     ref_f;
  stack_addr_t ref_sp;
  nibble_t     ref_stack [256];

  push_unit_top #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .STACK_WORDS (STACK_WORDS)
  ) dut_i (
    .clk     (clk),
    .rst     (rst),
    .op_req  (op_req),
    .opcode  (opcode),
    .op_ack  (op_ack),
    .sp      (sp),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .idle    (idle)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic void ref_reset();
    ref_a  = '0;
    ref_b  = '0;
    ref_xp = '0;
    ref_xh = '0;
    ref_xl = '0;
    ref_yp = '0;
    ref_yh = '0;
    ref_yl = '0;
    ref_f  = '0;
    ref_sp = 8'h00;
  endfunction

  // Pre-decrement, then store at the new SP
  function automatic void ref_push(input nibble_t val);
    ref_sp = ref_sp - 8'd1;
    ref_stack[ref_sp] = val;
  endfunction

  function automatic void ref_exec(input opcode_t op);
    nibble_t lo;
    lo = op[3:0];
    if (op == DEC_SP) begin
      ref_sp = ref_sp - 8'd1;
    end else if (op == INC_SP) begin
      ref_sp = ref_sp + 8'd1;
    end else if (op[11:4] == PUSH_BASE[11:4]) begin
      case (lo)
        4'h0:    ref_push(ref_a);
        4'h1:    ref_push(ref_b);
        PUSH_XP: ref_push(ref_xp);
        PUSH_XH: ref_push(ref_xh);
        PUSH_XL: ref_push(ref_xl);
        PUSH_YP: ref_push(ref_yp);
        PUSH_YH: ref_push(ref_yh);
        PUSH_YL: ref_push(ref_yl);
        PUSH_F:  ref_push(ref_f);
        default: ;
      endcase
    end else if (op[11:4] == LD_A_BASE[11:4]) begin
      ref_a = lo;
    end else if (op[11:4] == LD_B_BASE[11:4]) begin
      ref_b = lo;
    end else if (op[11:8] == LD_X_BASE[11:8]) begin
      ref_xh = op[7:4];
      ref_xl = lo;
    end else if (op[11:8] == LD_Y_BASE[11:8]) begin
      ref_yh = op[7:4];
      ref_yl = lo;
    end else if (op[11:2] == LD_XP_BASE[11:2]) begin
      ref_xp = (op[1:0] == REG_A) ? ref_a : (op[1:0] == REG_B) ? ref_b : ref_xp;
    end else if (op[11:2] == LD_YP_BASE[11:2]) begin
      ref_yp = (op[1:0] == REG_A) ? ref_a : (op[1:0] == REG_B) ? ref_b : ref_yp;
    end else if (op[11:4] == SET_F_BASE[11:4]) begin
      ref_f = ref_f | lo;
    end else if (op[11:4] == RST_F_BASE[11:4]) begin
      ref_f = ref_f & lo;
    end
  endfunction

  function automatic nibble_t rand_nibble();
    return nibble_t'($random(seed));
  endfunction

  function automatic imm8_t rand_byte();
    return imm8_t'($random(seed));
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic wait_ack(input logic level);
    @(negedge clk);
    while (op_ack !== level)
      @(negedge clk);
  endtask

  // Full four-phase cycle for one opcode
  task automatic send_op(input opcode_t op);
    @(posedge clk);
    opcode <= op;
    op_req <= 1'b1;
    wait_ack(1'b1);
    @(posedge clk);
    op_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic run_op(input string name, input opcode_t op);
    send_op(op);
    ref_exec(op);
    test_name = $sformatf("%s %03h", name, op);
    -> op_done;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!idle)
      @(negedge clk);
  endtask

  task automatic check_stack(input string name, input stack_addr_t addr);
    @(posedge clk);
    rd_addr <= addr;
    @(negedge clk);
    check_eq($sformatf("%s @%02h", name, addr), 32'(ref_stack[addr]), 32'(rd_data));
  endtask

  // SP is compared with the model after every opcode
  initial begin : compare
    forever begin
      @(op_done);
      check_eq({test_name, " sp"}, 32'(ref_sp), 32'(sp));
    end
  end

  task automatic reset_state();
    @(negedge clk);
    check_eq("reset op_ack", 32'h0, 32'(op_ack));
    check_eq("reset idle", 32'h1, 32'(idle));
    check_eq("reset sp", 32'(ref_sp), 32'(sp));
  endtask

  task automatic reg_pushes();
    nibble_t sel [$];
    nibble_t tmp;
    int      j;
    sel = '{4'h0, 4'h1, PUSH_XP, PUSH_XH, PUSH_XL, PUSH_YP, PUSH_YH, PUSH_YL};
    run_op("ld_a", {LD_A_BASE[11:4], rand_nibble()});
    run_op("ld_b", {LD_B_BASE[11:4], rand_nibble()});
    run_op("ld_xp_a", {LD_XP_BASE[11:2], REG_A});
    run_op("ld_yp_b", {LD_YP_BASE[11:2], REG_B});
    run_op("ld_a", {LD_A_BASE[11:4], rand_nibble()});
    run_op("ld_x", {LD_X_BASE[11:8], rand_byte()});
    run_op("ld_y", {LD_Y_BASE[11:8], rand_byte()});
    // Random push order
    for (int i = 7; i > 0; i--) begin
      j = $unsigned($random(seed)) % (i + 1);
      tmp = sel[i];
      sel[i] = sel[j];
      sel[j] = tmp;
    end
    foreach (sel[i]) begin
      run_op("push_reg", {PUSH_BASE[11:4], sel[i]});
      wait_idle();
      check_stack("push_reg data", ref_sp);
    end
  endtask

  task automatic flag_pushes();
    repeat (2) begin
      run_op("set_f", {SET_F_BASE[11:4], rand_nibble()});
      run_op("rst_f", {RST_F_BASE[11:4], rand_nibble()});
      run_op("set_f", {SET_F_BASE[11:4], rand_nibble()});
      run_op("push_f", {PUSH_BASE[11:4], PUSH_F});
      wait_idle();
      check_stack("push_f data", ref_sp);
    end
  endtask

  task automatic mx_my_noops();
    run_op("push_mx", {PUSH_BASE[11:4], 4'h2});
    run_op("push_my", {PUSH_BASE[11:4], 4'h3});
  endtask

  task automatic sp_wrap();
    while (ref_sp != 8'h00)
      run_op("inc_sp", INC_SP);
    run_op("dec_sp wrap", DEC_SP);
    run_op("inc_sp wrap", INC_SP);
  endtask

  task automatic push_burst();
    nibble_t     sel [$];
    stack_addr_t addr;
    int          k;
    sel = '{4'h0, 4'h1, PUSH_XP, PUSH_XH, PUSH_XL, PUSH_YP, PUSH_YH, PUSH_YL, PUSH_F};
    run_op("ld_a", {LD_A_BASE[11:4], rand_nibble()});
    run_op("ld_b", {LD_B_BASE[11:4], rand_nibble()});
    addr = ref_sp;
    // No idle wait between pushes
    for (int i = 0; i < BURST_LEN; i++) begin
      k = $unsigned($random(seed)) % 9;
      run_op("burst push", {PUSH_BASE[11:4], sel[k]});
    end
    wait_idle();
    for (int i = 0; i < BURST_LEN; i++) begin
      addr = addr - 8'd1;
      check_stack("burst data", addr);
    end
  endtask

  initial begin : watchdog
    repeat (N_OPS * 40 + 200) @(posedge clk);
    $display("Timeout: the run did not finish within the expected number of cycles");
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin : stimulus
    rst     = 1'b1;
    op_req  = 1'b0;
    opcode  = '0;
    rd_addr = '0;
    ref_reset();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    reset_state();
    reg_pushes();
    flag_pushes();
    mx_my_noops();
    sp_wrap();
    push_burst();
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== all.f ====
common/isa_pkg.sv
common/stack_pkg.sv
common/stack_wr_if.sv
core/insn_exec.sv
core/stack_fifo.sv
src/stack_ram.sv
src/push_unit_top.sv
verif/push_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f all.f --top-module push_unit_tb -o push_unit_sim

# The simulator status is masked by tee, the log decides
./obj_dir/push_unit_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
